//--- hw/pool_defines.svh
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// Channels per atom, also words per DMA burst
`define BURST_LEN 8

// One feature-map word, two's complement
`define DATA_W 16

// Window is 2^win_log2 atoms, so at most 8 atoms
`define MAX_WIN_LOG2 3

// Sum of 8 words never overflows 16 + 3 bits
`define SUM_W (`DATA_W + `MAX_WIN_LOG2)

`endif

//--- hw/pool_pkg.sv
package pool_pkg;

	`include "pool_defines.svh"

	// Opcode values follow the engine command encoding
	typedef enum logic [2:0] {
		OP_MPOOL = 3'd2, // Max pooling
		OP_APOOL = 3'd3  // Average pooling
	} pool_op_e;

	typedef enum logic [1:0] {
		ST_IDLE,  // Waiting for a command
		ST_BUSY,  // Fetching atoms
		ST_DRAIN, // Last atom issued, waiting for writeback
		ST_DONE   // One-cycle completion
	} ctrl_state_e;

	// Lane 0 sits in the low 16 bits
	typedef logic signed [`BURST_LEN-1:0][`DATA_W-1:0] atom_t;

	typedef struct packed {
		pool_op_e    op;
		logic [1:0]  win_log2; // Atoms per window = 2^win_log2
		logic [7:0]  num_win;  // Window count minus one
	} pool_cmd_t;

	typedef struct packed {
		logic valid; // New atom this cycle
		logic first; // Opens a window
		logic last;  // Closes a window
	} pool_step_t;

	typedef struct packed {
		logic  valid;
		logic  final_win; // Last window of the command
		atom_t atom;
	} pool_res_t;

endpackage

//--- hw/atom_deserializer.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module atom_deserializer import pool_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_req,        // Fetch one atom
	input  logic               i_rd_we,      // Word strobe from DMA
	input  logic [`DATA_W-1:0] i_rd_data,
	output logic               o_rd_en,      // Read request to DMA
	output logic               o_atom_valid, // Full atom in o_atom
	output atom_t              o_atom
);

	logic [$clog2(`BURST_LEN)-1:0] word_cnt; // Words taken for current atom

	// Request and word count
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_rd_en      <= 1'b0;
			o_atom_valid <= 1'b0;
			word_cnt     <= '0;
		end else begin
			o_atom_valid <= 1'b0; // Single-cycle pulse
			if (i_req)
				o_rd_en <= 1'b1;
			if (i_rd_we) begin
				if (word_cnt == `BURST_LEN-1) begin
					// 8th word drops the request on this same edge
					o_rd_en      <= 1'b0;
					word_cnt     <= '0;
					o_atom_valid <= 1'b1;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	// Shift in from the top so the first word lands in lane 0
	always_ff @(posedge clk) begin
		if (i_rd_we)
			o_atom <= {i_rd_data, o_atom[`BURST_LEN-1:1]};
	end

endmodule

//--- hw/pool_ctrl.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module pool_ctrl import pool_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_valid,      // Command valid
	input  pool_cmd_t  i_cmd,
	input  logic       i_atom_valid, // Atom ready in deserializer
	output logic       o_ready,
	output logic       o_req,        // Ask deserializer for next atom
	output pool_step_t o_step,
	output pool_cmd_t  o_cmd,
	output logic       o_final_win,  // Qualifies o_step.last
	input  logic       i_wb_idle,
	output logic       o_done
);

	ctrl_state_e                  state;
	pool_cmd_t                    cmd;
	logic [`MAX_WIN_LOG2-1:0]     atom_cnt;  // Atom index inside window
	logic [`MAX_WIN_LOG2-1:0]     atom_last; // 2^win_log2 - 1
	logic [7:0]                   win_cnt;   // Window index inside command
	logic                         pend;      // One atom request outstanding
	logic                         wb_seen;   // Final writeback has started
	logic                         at_last;
	logic                         win_final;

	assign atom_last = ~({`MAX_WIN_LOG2{1'b1}} << cmd.win_log2); // Low win_log2 bits set
	assign at_last   = (atom_cnt == atom_last);
	assign win_final = (win_cnt == cmd.num_win);

	assign o_ready = (state == ST_IDLE);
	assign o_done  = (state == ST_DONE);
	assign o_cmd   = cmd;

	// Command held for the whole run
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_valid)
			cmd <= i_cmd;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= ST_IDLE;
			atom_cnt    <= '0;
			win_cnt     <= '0;
			pend        <= 1'b0;
			wb_seen     <= 1'b0;
			o_req       <= 1'b0;
			o_step      <= '0;
			o_final_win <= 1'b0;
		end else begin
			o_req  <= 1'b0; // Pulses only
			o_step <= '0;
			case (state)
				ST_IDLE: begin
					if (i_valid) begin
						atom_cnt <= '0;
						win_cnt  <= '0;
						o_req    <= 1'b1; // First atom right away
						pend     <= 1'b1;
						state    <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (i_atom_valid && pend) begin
						pend        <= 1'b0;
						o_step      <= '{valid: 1'b1, first: (atom_cnt == '0), last: at_last};
						o_final_win <= win_final;
						if (at_last) begin
							atom_cnt <= '0;
							if (win_final) begin
								wb_seen <= 1'b0;
								state   <= ST_DRAIN; // Nothing more to fetch
							end else begin
								win_cnt <= win_cnt + 8'd1;
								o_req   <= 1'b1;
								pend    <= 1'b1;
							end
						end else begin
							atom_cnt <= atom_cnt + 1'b1;
							o_req    <= 1'b1;
							pend     <= 1'b1;
						end
					end
				end
				ST_DRAIN: begin
					// Idle is high before the final result lands, so wait for busy first
					if (!i_wb_idle)
						wb_seen <= 1'b1;
					else if (wb_seen)
						state <= ST_DONE;
				end
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hw/max_pool_unit.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module max_pool_unit import pool_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  pool_step_t i_step,
	input  logic       i_final_win,
	input  atom_t      i_atom,
	output pool_res_t  o_res
);

	atom_t run_max; // Running maximum per lane
	atom_t nxt_max; // Maximum including current atom
	atom_t res_atom;
	logic  res_valid;
	logic  res_final;

	// Signed compare per lane where a window's first atom loads directly
	always_comb begin
		for (int l = 0; l < `BURST_LEN; l++) begin
			if (i_step.first || ($signed(i_atom[l]) > $signed(run_max[l])))
				nxt_max[l] = i_atom[l];
			else
				nxt_max[l] = run_max[l];
		end
	end

	always_ff @(posedge clk) begin
		if (i_step.valid)
			run_max <= nxt_max;
		if (i_step.valid && i_step.last)
			res_atom <= nxt_max; // Window result
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			res_valid <= 1'b0;
			res_final <= 1'b0;
		end else begin
			res_valid <= i_step.valid && i_step.last; // One cycle per window
			if (i_step.valid && i_step.last)
				res_final <= i_final_win;
		end
	end

	assign o_res = '{valid: res_valid, final_win: res_final, atom: res_atom};

endmodule

//--- hw/avg_pool_unit.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module avg_pool_unit import pool_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  pool_step_t i_step,
	input  logic       i_final_win,
	input  logic [1:0] i_win_log2,
	input  atom_t      i_atom,
	output pool_res_t  o_res
);

	logic [`BURST_LEN-1:0][`SUM_W-1:0] acc;     // Running sums
	logic [`BURST_LEN-1:0][`SUM_W-1:0] nxt_acc; // Sums including current atom
	logic [`BURST_LEN-1:0][`SUM_W-1:0] shifted; // Floor average, still wide
	atom_t                             avg_atom;
	atom_t                             res_atom;
	logic                              res_valid;
	logic                              res_final;

	always_comb begin
		for (int l = 0; l < `BURST_LEN; l++) begin
			// Sign-extend the word, restart the sum on a window's first atom
			nxt_acc[l] = (i_step.first ? '0 : acc[l]) +
				{{`MAX_WIN_LOG2{i_atom[l][`DATA_W-1]}}, i_atom[l]};
			shifted[l] = $signed(nxt_acc[l]) >>> i_win_log2; // Arithmetic shift rounds down
			avg_atom[l] = shifted[l][`DATA_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (i_step.valid)
			acc <= nxt_acc;
		if (i_step.valid && i_step.last)
			res_atom <= avg_atom;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			res_valid <= 1'b0;
			res_final <= 1'b0;
		end else begin
			res_valid <= i_step.valid && i_step.last;
			if (i_step.valid && i_step.last)
				res_final <= i_final_win;
		end
	end

	assign o_res = '{valid: res_valid, final_win: res_final, atom: res_atom};

endmodule

//--- hw/pool_writeback.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module pool_writeback import pool_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  pool_op_e           i_op,
	input  pool_res_t          i_max_res,
	input  pool_res_t          i_avg_res,
	output logic               o_wr_en,
	output logic [`DATA_W-1:0] o_wr_data,
	output logic               o_idle
);

	pool_res_t                     sel;    // Result of the unit the opcode picks
	atom_t                         wb_buf; // Atom being serialized
	logic [$clog2(`BURST_LEN)-1:0] lane;   // Lane on the port this cycle
	logic                          active; // Lanes still going out
	logic                          fin;    // Buffer holds the command's last window
	logic                          last_lane;

	assign sel       = (i_op == OP_APOOL) ? i_avg_res : i_max_res;
	assign last_lane = (lane == `BURST_LEN-1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			lane   <= '0;
			fin    <= 1'b0;
		end else begin
			if (sel.valid) begin
				active <= 1'b1; // Lane 0 goes out next cycle
				lane   <= '0;
				fin    <= sel.final_win;
			end else if (active) begin
				lane <= lane + 1'b1;
				if (last_lane)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sel.valid)
			wb_buf <= sel.atom;
	end

	assign o_wr_en   = active;
	assign o_wr_data = wb_buf[lane];

	// On the final window, report idle already during the last lane
	// so done follows the last word directly
	assign o_idle = ~active | (fin & last_lane);

endmodule

//--- hw/pool_engine.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module pool_engine import pool_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	// Command
	input  logic               i_valid,
	input  pool_cmd_t          i_cmd,
	output logic               o_ready,
	// DMA read port
	output logic               o_rd_en,
	input  logic               i_rd_we,
	input  logic [`DATA_W-1:0] i_rd_data,
	// DMA write port
	output logic               o_wr_en,
	output logic [`DATA_W-1:0] o_wr_data,
	output logic               o_done
);

	logic       req;        // Controller asks for an atom
	logic       atom_valid;
	atom_t      atom;
	pool_step_t step;
	pool_cmd_t  cmd;        // Held command
	logic       final_win;
	pool_res_t  max_res;
	pool_res_t  avg_res;
	logic       wb_idle;

	atom_deserializer deser_i (
		.clk          (clk),
		.rst          (rst),
		.i_req        (req),
		.i_rd_we      (i_rd_we),
		.i_rd_data    (i_rd_data),
		.o_rd_en      (o_rd_en),
		.o_atom_valid (atom_valid),
		.o_atom       (atom)
	);

	pool_ctrl ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.i_valid      (i_valid),
		.i_cmd        (i_cmd),
		.i_atom_valid (atom_valid),
		.o_ready      (o_ready),
		.o_req        (req),
		.o_step       (step),
		.o_cmd        (cmd),
		.o_final_win  (final_win),
		.i_wb_idle    (wb_idle),
		.o_done       (o_done)
	);

	// Both units see every atom, writeback picks one
	max_pool_unit max_i (
		.clk         (clk),
		.rst         (rst),
		.i_step      (step),
		.i_final_win (final_win),
		.i_atom      (atom),
		.o_res       (max_res)
	);

	avg_pool_unit avg_i (
		.clk         (clk),
		.rst         (rst),
		.i_step      (step),
		.i_final_win (final_win),
		.i_win_log2  (cmd.win_log2),
		.i_atom      (atom),
		.o_res       (avg_res)
	);

	pool_writeback wb_i (
		.clk       (clk),
		.rst       (rst),
		.i_op      (cmd.op),
		.i_max_res (max_res),
		.i_avg_res (avg_res),
		.o_wr_en   (o_wr_en),
		.o_wr_data (o_wr_data),
		.o_idle    (wb_idle)
	);

endmodule

//--- tests/pool_engine_props.sv
`timescale 1ns/1ps

module pool_engine_props (
	input logic clk,
	input logic rst,
	input logic i_valid,
	input logic o_ready,
	input logic o_rd_en,
	input logic i_rd_we,
	input logic o_wr_en,
	input logic o_done
);

	int unsigned fail_cnt = 0; // Failed assertions so far

	// No port activity under reset
	a_quiet_in_reset: assert property (@(posedge clk) rst |-> (!o_wr_en && !o_rd_en))
		else begin
			fail_cnt++;
			$error("read or write active during reset");
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) o_done |=> !o_done)
		else begin
			fail_cnt++;
			$error("done held longer than one cycle");
		end

	// Accepted command makes the engine busy
	a_busy_after_accept: assert property (@(posedge clk) disable iff (rst)
		(i_valid && o_ready) |=> !o_ready)
		else begin
			fail_cnt++;
			$error("ready still high after command accept");
		end

	a_not_ready_busy: assert property (@(posedge clk) disable iff (rst)
		(o_rd_en || o_wr_en || o_done) |-> !o_ready)
		else begin
			fail_cnt++;
			$error("ready high while engine busy");
		end

	a_strobe_in_request: assert property (@(posedge clk) disable iff (rst) i_rd_we |-> o_rd_en)
		else begin
			fail_cnt++;
			$error("read strobe outside a read request");
		end

endmodule

bind pool_engine pool_engine_props props_i (
	.clk     (clk),
	.rst     (rst),
	.i_valid (i_valid),
	.o_ready (o_ready),
	.o_rd_en (o_rd_en),
	.i_rd_we (i_rd_we),
	.o_wr_en (o_wr_en),
	.o_done  (o_done)
);

//--- tests/tb_pool_engine.sv
`timescale 1ns/1ps
`include "pool_defines.svh"

module tb_pool_engine import pool_pkg::*; ();

	localparam int CLK_PERIOD  = 100;
	localparam int TOTAL_WORDS = 776; // 120 max + 144 avg + 32 no-gap + 480 alternating

	logic               clk;
	logic               rst;
	logic               i_valid;
	pool_cmd_t          i_cmd;
	logic               o_ready;
	logic               o_rd_en;
	logic               i_rd_we;
	logic [`DATA_W-1:0] i_rd_data;
	logic               o_wr_en;
	logic [`DATA_W-1:0] o_wr_data;
	logic               o_done;

	logic [`DATA_W-1:0] feed_q[$]; // Words the DMA source still has to send
	logic [`DATA_W-1:0] exp_q[$];  // Expected write data, lane 0 first
	bit                 gaps;      // Random idle cycles between strobes
	int                 wr_cnt;
	int                 done_cnt;
	int                 overlap_cnt; // Cycles with a write and a read strobe together

	pool_engine dut_i (
		.clk       (clk),
		.rst       (rst),
		.i_valid   (i_valid),
		.i_cmd     (i_cmd),
		.o_ready   (o_ready),
		.o_rd_en   (o_rd_en),
		.i_rd_we   (i_rd_we),
		.i_rd_data (i_rd_data),
		.o_wr_en   (o_wr_en),
		.o_wr_data (o_wr_data),
		.o_done    (o_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abort_run($sformatf("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, want));
	endtask

	// Expected lanes for one window from words in arrival order
	function automatic atom_t ref_pool(input pool_op_e op, input int wl2,
		input logic signed [`DATA_W-1:0] words [64]);
		atom_t                     res;
		logic signed [`DATA_W-1:0] mx;
		int                        sum;
		int                        a;
		int                        l;
		for (l = 0; l < `BURST_LEN; l++) begin
			mx  = words[l];
			sum = 0;
			for (a = 0; a < (1 << wl2); a++) begin
				if (words[a*`BURST_LEN + l] > mx)
					mx = words[a*`BURST_LEN + l];
				sum += words[a*`BURST_LEN + l]; // Sign-extended into int
			end
			if (op == OP_MPOOL)
				res[l] = mx;
			else
				res[l] = 16'(sum >>> wl2); // Floor for negative sums too
		end
		return res;
	endfunction

	function automatic logic [`DATA_W-1:0] gen_word(input bit neg_bias);
		logic [31:0] r;
		r = $urandom;
		if (neg_bias)
			return 16'(int'(r % 5000) - 4000); // Mostly negative
		return r[`DATA_W-1:0];
	endfunction

	// Queue data and expectations, issue the command, wait for done
	task automatic run_cmd(input pool_op_e op, input int wl2, input int nwin,
		input bit gap_on, input bit neg_bias);
		logic signed [`DATA_W-1:0] win_words [64];
		atom_t                     exp_atom;
		pool_cmd_t                 cmd;
		int                        w;
		int                        i;
		int                        l;
		int                        wr_start;
		int                        done_start;
		for (w = 0; w < nwin; w++) begin
			for (i = 0; i < (`BURST_LEN << wl2); i++) begin
				win_words[i] = gen_word(neg_bias);
				feed_q.push_back(win_words[i]);
			end
			exp_atom = ref_pool(op, wl2, win_words);
			for (l = 0; l < `BURST_LEN; l++)
				exp_q.push_back(exp_atom[l]);
		end
		gaps         = gap_on;
		cmd.op       = op;
		cmd.win_log2 = wl2[1:0];
		cmd.num_win  = 8'(nwin - 1);
		wr_start     = wr_cnt;
		done_start   = done_cnt;
		check_val("o_ready", o_ready, 1);
		i_cmd   = cmd;
		i_valid = 1'b1;
		@(posedge clk); // Accepted here since o_ready was high
		#1;
		i_valid = 1'b0;
		while (done_cnt == done_start)
			@(posedge clk);
		#1;
		check_val("o_ready", o_ready, 1); // Back one cycle after done
		check_val("o_done count", done_cnt - done_start, 1);
		check_val("o_wr_en count", wr_cnt - wr_start, `BURST_LEN * nwin);
		check_val("pending expected", exp_q.size(), 0);
	endtask

	// DMA source strobes only while a request is open
	initial begin : dma_source
		forever begin
			@(posedge clk);
			#1;
			i_rd_we = 1'b0;
			if (o_rd_en && !rst) begin
				if (feed_q.size() == 0)
					abort_run("DMA read request with no words left to send");
				else if (!gaps || ($urandom % 3) != 0) begin
					i_rd_we   = 1'b1;
					i_rd_data = feed_q.pop_front();
				end
			end
		end
	end

	// Compare at mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (!rst && o_wr_en) begin
			if (exp_q.size() == 0)
				abort_run("Write on the DMA port with no expected value pending");
			else
				check_val("o_wr_data", o_wr_data, exp_q.pop_front());
			wr_cnt++;
			if (i_rd_we)
				overlap_cnt++;
		end
		if (!rst && o_done)
			done_cnt++;
	end

	initial begin : watchdog
		repeat (4 * TOTAL_WORDS * 20) @(posedge clk);
		abort_run("Watchdog timeout, the test sequence did not complete");
	end

	initial begin : main_seq
		pool_op_e op_sel;
		int       k;
		int       ov_start;
		rst         = 1'b1;
		i_valid     = 1'b0;
		i_cmd       = '0;
		i_rd_we     = 1'b0;
		i_rd_data   = '0;
		gaps        = 1'b0;
		wr_cnt      = 0;
		done_cnt    = 0;
		overlap_cnt = 0;
		void'($urandom(32'h80cc527b));
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle after reset
		check_val("o_ready", o_ready, 1);
		repeat (5) @(posedge clk);
		#1;
		check_val("o_wr_en count", wr_cnt, 0);

		for (k = 0; k < 4; k++)
			run_cmd(OP_MPOOL, k, 1, 1'b1, 1'b0); // One window per size

		run_cmd(OP_APOOL, 3, 2, 1'b1, 1'b1); // Negative averages
		run_cmd(OP_APOOL, 1, 1, 1'b1, 1'b1);

		// Gapless strobes so writeback must run during the next fetch
		ov_start = overlap_cnt;
		run_cmd(OP_MPOOL, 0, 4, 1'b0, 1'b0);
		check_val("writeback overlap", overlap_cnt > ov_start, 1);

		for (k = 0; k < 8; k++) begin
			if (k % 2 == 1)
				op_sel = OP_APOOL;
			else
				op_sel = OP_MPOOL;
			run_cmd(op_sel, k % 4, 2, 1'b1, 1'b0);
		end
		check_val("o_done total", done_cnt, 15);

		if (dut_i.props_i.fail_cnt == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Assertion failures seen: %0d", dut_i.props_i.fail_cnt);
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule

//--- compile.f
+incdir+hw
hw/pool_pkg.sv
hw/atom_deserializer.sv
hw/pool_ctrl.sv
hw/max_pool_unit.sv
hw/avg_pool_unit.sv
hw/pool_writeback.sv
hw/pool_engine.sv
tests/pool_engine_props.sv
tests/tb_pool_engine.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pool_engine
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
